//--- filelist.f
+incdir+.
zx81_pkg.sv
cpu_bus_if.sv
memory_map.sv
io_ports.sv
bus_read_mux.sv
zx81_bus_top.sv
tb_clock_gen.sv
tb_zx81_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ZX81 bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_zx81_bus -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

exit 0

//--- tb_zx81_bus.sv
`timescale 1ns/10ps
`default_nettype none

`include "zx81_params.svh"

module tb_zx81_bus;

	localparam logic [2:0] OP_IDLE = 3'd0;
	localparam logic [2:0] OP_RESET = 3'd1;
	localparam logic [2:0] OP_LOAD = 3'd2;
	localparam logic [2:0] OP_MRD = 3'd3;
	localparam logic [2:0] OP_MWR = 3'd4;
	localparam logic [2:0] OP_IRD = 3'd5;
	localparam logic [2:0] OP_IWR = 3'd6;

	typedef struct packed {
		logic [2:0] op;
		zx81_pkg::cpu_addr_t addr;
		zx81_pkg::cpu_data_t wdata;
		logic m1_n;
		zx81_pkg::mem_size_t mem_size;
		logic low_ram_en;
		zx81_pkg::key_matrix_t keys;
		zx81_pkg::joy_t joy;
		logic [1:0] joy_mode;
		logic hz50;
		logic chroma_en;
		zx81_pkg::cpu_data_t exp;
	} step_t;

	logic clk_sys;
	logic reset;
	zx81_pkg::cpu_addr_t addr;
	zx81_pkg::cpu_data_t wdata;
	logic m1_n;
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	zx81_pkg::mem_size_t mem_size;
	logic low_ram_en;
	logic rom_load_we;
	zx81_pkg::rom_addr_t rom_load_addr;
	zx81_pkg::cpu_data_t rom_load_data;
	zx81_pkg::key_matrix_t key_matrix;
	zx81_pkg::joy_t joystick;
	logic [1:0] joy_mode;
	logic hz50;
	logic chroma_en;
	zx81_pkg::cpu_data_t cpu_din;

	tb_clock_gen clk0 (.clk_sys(clk_sys));

	zx81_bus_top dut0 (.*);

	// ============================================================
	// Reference model state
	// ============================================================

	step_t tbl [$];
	zx81_pkg::cpu_data_t m_ram [`ZX81_RAM_WORDS];
	zx81_pkg::cpu_data_t m_rom [`ZX81_ROM_WORDS];
	zx81_pkg::cpu_data_t m_zxp;
	logic m_zxp_joy;
	zx81_pkg::mem_size_t lat_size;
	logic lat_low;
	logic [31:0] seed = 32'h1e30_deb5;
	int cycles = 0;
	int limit = 200;

	// Settings of the step being built
	zx81_pkg::mem_size_t cur_size;
	logic cur_low;
	zx81_pkg::key_matrix_t cur_keys;
	zx81_pkg::joy_t cur_joy;
	logic [1:0] cur_mode;
	logic cur_hz50;
	logic cur_chroma;

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = seed;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		seed = x;
		return x;
	endfunction

	function automatic logic rom_mapped(input zx81_pkg::cpu_addr_t a);
		return (a[14:13] == 2'b00) && !(a[15] && lat_size[1]);
	endfunction

	// Bit 16 set when the address lands in RAM
	function automatic logic [16:0] ram_lookup(input zx81_pkg::cpu_addr_t a, input logic m1n);
		logic top;
		top = a[15] & lat_size[1];
		if (!top && a[14:13] == 2'b01)
			return lat_low ? {1'b1, 3'b001, a[12:0]} : 17'd0;
		if (top && !a[14])
			return {1'b1, 2'b10, a[13:0]};
		if (top && lat_size[0] && m1n)
			return {1'b1, 2'b11, a[13:0]};
		if (!a[14])
			return 17'd0;
		if (lat_size == 2'd0)
			return {1'b1, 6'b010000, a[9:0]};
		return {1'b1, 2'b01, a[13:0]};
	endfunction

	// Keys pulled low by the joystick, active low mask
	function automatic logic [4:0] joy_mask(input step_t s);
		logic [4:0] m;
		logic [4:0] j;
		m = 5'h1F;
		j = s.joy;
		if (m_zxp_joy)
			return m;
		if (!s.addr[12] && s.joy_mode == 2'd0)
			m = m & ~{j[2], j[3], j[0], 1'b0, j[4]};
		if (!s.addr[11] && s.joy_mode == 2'd0)
			m = m & ~{j[1], 4'b0000};
		if (!s.addr[12] && s.joy_mode[0])
			m = m & ~{j[1], j[0], j[2], j[3], j[4]};
		if (!s.addr[12] && s.joy_mode[1])
			m = m & ~{j[2], j[3], j[0], j[1], j[4]};
		return m;
	endfunction

	function automatic zx81_pkg::cpu_data_t port_read(input step_t s);
		zx81_pkg::key_row_t rows;
		int n;
		rows = 5'h1F;
		if (!s.addr[0]) begin
			for (n = 0; n < 8; n++) begin
				if (!s.addr[8 + n])
					rows = rows & s.keys[5 * n +: 5];
			end
			return {1'b0, s.hz50, 1'b0, rows & joy_mask(s)};
		end
		if (s.addr == `ZX81_ZXP_PORT)
			return m_zxp;
		if (s.addr == `ZX81_CHR_PORT && s.chroma_en)
			return `ZX81_CHR_ID;
		return `ZX81_OPEN_BUS;
	endfunction

	// Append one step and advance the model
	task automatic add_step(input logic [2:0] op, input zx81_pkg::cpu_addr_t a,
		input zx81_pkg::cpu_data_t d, input logic m1n);
		step_t s;
		logic [16:0] r;
		s.op = op;
		s.addr = a;
		s.wdata = d;
		s.m1_n = m1n;
		s.mem_size = cur_size;
		s.low_ram_en = cur_low;
		s.keys = cur_keys;
		s.joy = cur_joy;
		s.joy_mode = cur_mode;
		s.hz50 = cur_hz50;
		s.chroma_en = cur_chroma;
		s.exp = `ZX81_OPEN_BUS;
		r = ram_lookup(a, m1n);
		case (op)
			OP_RESET: begin
				lat_size = cur_size;
				lat_low = cur_low;
				m_zxp = 8'hFF;
				m_zxp_joy = 1'b0;
			end
			OP_LOAD: m_rom[a[12:0]] = d;
			OP_MWR: begin
				if (r[16])
					m_ram[r[15:0]] = d;
			end
			OP_MRD: begin
				if (rom_mapped(a))
					s.exp = m_rom[a[12:0]];
				else if (r[16])
					s.exp = m_ram[r[15:0]];
			end
			OP_IWR: begin
				if (a == `ZX81_ZXP_PORT) begin
					case (d)
						`ZX81_ZXP_CODE_A: m_zxp = 8'hF0;
						`ZX81_ZXP_CODE_B: m_zxp = 8'h0F;
						`ZX81_ZXP_CODE_JOY: begin
							m_zxp = {~cur_joy[3:0], ~cur_joy[4], 3'b000};
							m_zxp_joy = 1'b1;
						end
						default: m_zxp = 8'hFF;
					endcase
				end
			end
			OP_IRD: s.exp = port_read(s);
			default: ;
		endcase
		tbl.push_back(s);
	endtask

	// ============================================================
	// Bus driving and checking
	// ============================================================

	task automatic drive_step(input step_t s);
		addr <= s.addr;
		wdata <= s.wdata;
		m1_n <= s.m1_n;
		mreq_n <= !(s.op == OP_MRD || s.op == OP_MWR);
		iorq_n <= !(s.op == OP_IRD || s.op == OP_IWR);
		rd_n <= !(s.op == OP_MRD || s.op == OP_IRD);
		wr_n <= !(s.op == OP_MWR || s.op == OP_IWR);
		reset <= (s.op == OP_RESET);
		rom_load_we <= (s.op == OP_LOAD);
		rom_load_addr <= s.addr[12:0];
		rom_load_data <= s.wdata;
		mem_size <= s.mem_size;
		low_ram_en <= s.low_ram_en;
		key_matrix <= s.keys;
		joystick <= s.joy;
		joy_mode <= s.joy_mode;
		hz50 <= s.hz50;
		chroma_en <= s.chroma_en;
	endtask

	task automatic release_bus();
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		m1_n <= 1'b1;
		rom_load_we <= 1'b0;
		reset <= 1'b0;
	endtask

	task automatic check_byte(input zx81_pkg::cpu_data_t got, input zx81_pkg::cpu_data_t exp,
		input int step);
		if (got !== exp) begin
			$display("[FAIL] %0t: step %0d read %02h, expected %02h", $time, step, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "read data mismatch");
		end
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles before the step table was done", cycles);
			$display("STATUS: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	// ============================================================
	// Step table and run
	// ============================================================

	initial begin
		int i;
		logic [31:0] r;
		logic [31:0] r2;
		zx81_pkg::cpu_addr_t a;
		zx81_pkg::rom_addr_t rom_a [16];
		zx81_pkg::cpu_addr_t lo_a;
		release_bus();
		addr <= '0;
		wdata <= '0;
		mem_size <= 2'd1;
		low_ram_en <= 1'b0;
		rom_load_addr <= '0;
		rom_load_data <= '0;
		key_matrix <= '1;
		joystick <= '0;
		joy_mode <= 2'd0;
		hz50 <= 1'b0;
		chroma_en <= 1'b0;
		cur_size = 2'd1;
		cur_low = 1'b1;
		cur_keys = '1;
		cur_joy = '0;
		cur_mode = 2'd0;
		cur_hz50 = 1'b1;
		cur_chroma = 1'b0;
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);

		// ROM load, read back, bus writes ignored, mirror at 8000h
		for (i = 0; i < 16; i++) begin
			r = xorshift();
			rom_a[i] = r[12:0];
			add_step(OP_LOAD, {3'b000, r[12:0]}, r[23:16], 1'b1);
		end
		for (i = 0; i < 16; i++) begin
			r = xorshift();
			add_step(OP_MRD, {3'b000, rom_a[i]}, 8'h00, 1'b1);
			add_step(OP_MWR, {3'b000, rom_a[i]}, r[7:0], 1'b1);
			add_step(OP_MRD, {3'b100, rom_a[i]}, 8'h00, 1'b0);
		end

		// 16K main RAM with C000h mirror, low RAM enabled
		for (i = 0; i < 8; i++) begin
			r = xorshift();
			a = {2'b01, r[13:0]};
			add_step(OP_MWR, a, r[23:16], 1'b1);
			add_step(OP_MRD, a, 8'h00, 1'b1);
			add_step(OP_MRD, a | 16'h8000, 8'h00, 1'b0);
		end
		r = xorshift();
		lo_a = {3'b001, r[12:0]};
		add_step(OP_MWR, lo_a, r[31:24], 1'b1);
		add_step(OP_MRD, lo_a, 8'h00, 1'b1);

		// 1K with 400h mirror, low RAM off
		cur_size = 2'd0;
		cur_low = 1'b0;
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);
		for (i = 0; i < 8; i++) begin
			r = xorshift();
			r2 = xorshift();
			add_step(OP_MWR, {6'b010000, r[9:0]}, r[23:16], 1'b1);
			add_step(OP_MRD, {2'b01, r2[3:0], r[9:0]}, 8'h00, 1'b1);
			add_step(OP_MRD, {2'b11, r2[7:4], r[9:0]}, 8'h00, 1'b1);
		end
		add_step(OP_MWR, lo_a, 8'h5A, 1'b1);
		add_step(OP_MRD, lo_a, 8'h00, 1'b1);

		// Size and low-RAM inputs change without reset, latched 1K stays
		cur_size = 2'd3;
		cur_low = 1'b1;
		add_step(OP_MRD, {2'b11, r2[7:4], r[9:0]}, 8'h00, 1'b1);
		add_step(OP_MRD, lo_a, 8'h00, 1'b1);
		cur_size = 2'd1;
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);
		add_step(OP_MRD, lo_a, 8'h00, 1'b1);

		// 32K then 48K banks
		cur_size = 2'd2;
		cur_low = 1'b0;
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);
		for (i = 0; i < 6; i++) begin
			r = xorshift();
			add_step(OP_MWR, {2'b01, r[13:0]}, r[23:16], 1'b1);
			add_step(OP_MWR, {2'b10, r[13:0]}, r[31:24], 1'b1);
			add_step(OP_MRD, {2'b01, r[13:0]}, 8'h00, 1'b1);
			add_step(OP_MRD, {2'b10, r[13:0]}, 8'h00, 1'b1);
			add_step(OP_MRD, {2'b11, r[13:0]}, 8'h00, 1'b1);
		end
		cur_size = 2'd3;
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);
		for (i = 0; i < 6; i++) begin
			r = xorshift();
			r2 = xorshift();
			add_step(OP_MWR, {2'b01, r[13:0]}, r[23:16], 1'b1);
			add_step(OP_MWR, {2'b11, r[13:0]}, r[31:24], 1'b1);
			add_step(OP_MWR, {2'b10, r[13:0]}, r2[7:0], 1'b1);
			add_step(OP_MRD, {2'b11, r[13:0]}, 8'h00, 1'b1);
			add_step(OP_MRD, {2'b11, r[13:0]}, 8'h00, 1'b0);
			add_step(OP_MRD, {2'b01, r[13:0]}, 8'h00, 1'b1);
			add_step(OP_MRD, {2'b10, r[13:0]}, 8'h00, 1'b1);
		end

		// Keyboard with every joystick mode and both enable rows
		for (i = 0; i < 32; i++) begin
			r = xorshift();
			r2 = xorshift();
			cur_keys = {r | r2, r[31:24] | r2[15:8]};
			cur_joy = r2[20:16];
			cur_mode = i[1:0];
			cur_hz50 = r2[21];
			a = {~(8'h01 << r2[26:24]), r[7:1], 1'b0};
			a[12] = a[12] & ~i[2];
			a[11] = a[11] & ~i[3];
			add_step(OP_IRD, a, 8'h00, 1'b1);
		end

		// Printer port codes, then joystick taken off the keyboard
		cur_keys = '1;
		cur_mode = 2'd0;
		r = xorshift();
		add_step(OP_IWR, `ZX81_ZXP_PORT, `ZX81_ZXP_CODE_A, 1'b1);
		add_step(OP_IRD, `ZX81_ZXP_PORT, 8'h00, 1'b1);
		add_step(OP_IWR, `ZX81_ZXP_PORT, `ZX81_ZXP_CODE_B, 1'b1);
		add_step(OP_IRD, `ZX81_ZXP_PORT, 8'h00, 1'b1);
		add_step(OP_IWR, `ZX81_ZXP_PORT, r[7:0], 1'b1);
		add_step(OP_IRD, `ZX81_ZXP_PORT, 8'h00, 1'b1);
		cur_joy = 5'b10110;
		add_step(OP_IWR, `ZX81_ZXP_PORT, `ZX81_ZXP_CODE_JOY, 1'b1);
		add_step(OP_IRD, `ZX81_ZXP_PORT, 8'h00, 1'b1);
		cur_joy = 5'h1F;
		add_step(OP_IRD, 16'hEFFE, 8'h00, 1'b1);
		add_step(OP_RESET, 16'h0000, 8'h00, 1'b1);
		add_step(OP_IRD, `ZX81_ZXP_PORT, 8'h00, 1'b1);
		add_step(OP_IRD, 16'hEFFE, 8'h00, 1'b1);

		// CHROMA81 id, other ports and idle cycles
		cur_chroma = 1'b0;
		add_step(OP_IRD, `ZX81_CHR_PORT, 8'h00, 1'b1);
		cur_chroma = 1'b1;
		add_step(OP_IRD, `ZX81_CHR_PORT, 8'h00, 1'b1);
		add_step(OP_IRD, 16'h00FF, 8'h00, 1'b1);
		add_step(OP_IDLE, 16'h4000, 8'h00, 1'b1);
		add_step(OP_IDLE, 16'h7FEF, 8'h00, 1'b1);

		limit = tbl.size() * 4 + 200;
		for (i = 0; i < tbl.size(); i++) begin
			@(posedge clk_sys);
			drive_step(tbl[i]);
			// Reset is held over two edges
			if (tbl[i].op == OP_RESET)
				@(posedge clk_sys);
			@(posedge clk_sys);
			release_bus();
			@(negedge clk_sys);
			check_byte(cpu_din, tbl[i].exp, i);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys
);

	// 50 MHz system clock
	initial clk_sys = 1'b0;

	always #10 clk_sys = ~clk_sys;

endmodule

`default_nettype wire

//--- zx81_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module zx81_bus_top (
	input wire logic clk_sys,
	input wire logic reset,
	input wire zx81_pkg::cpu_addr_t addr,
	input wire zx81_pkg::cpu_data_t wdata,
	input wire logic m1_n,
	input wire logic mreq_n,
	input wire logic iorq_n,
	input wire logic rd_n,
	input wire logic wr_n,
	input wire zx81_pkg::mem_size_t mem_size,
	input wire logic low_ram_en,
	input wire logic rom_load_we,
	input wire zx81_pkg::rom_addr_t rom_load_addr,
	input wire zx81_pkg::cpu_data_t rom_load_data,
	input wire zx81_pkg::key_matrix_t key_matrix,
	input wire zx81_pkg::joy_t joystick,
	input wire logic [1:0] joy_mode,
	input wire logic hz50,
	input wire logic chroma_en,
	output zx81_pkg::cpu_data_t cpu_din
);

	// ============================================================
	// CPU bus
	// ============================================================

	cpu_bus_if bus ();

	assign bus.addr = addr;
	assign bus.wdata = wdata;
	assign bus.m1_n = m1_n;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n = rd_n;
	assign bus.wr_n = wr_n;

	zx81_pkg::cpu_data_t mem_out;
	zx81_pkg::cpu_data_t io_out;
	logic mem_hit;

	memory_map mem0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.bus(bus.mem),
		.mem_size(mem_size),
		.low_ram_en(low_ram_en),
		.rom_load_we(rom_load_we),
		.rom_load_addr(rom_load_addr),
		.rom_load_data(rom_load_data),
		.mem_out(mem_out),
		.mem_hit(mem_hit)
	);

	io_ports io0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.bus(bus.io),
		.key_matrix(key_matrix),
		.joystick(joystick),
		.joy_mode(joy_mode),
		.hz50(hz50),
		.chroma_en(chroma_en),
		.io_out(io_out)
	);

	bus_read_mux mux0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.bus(bus.mux),
		.mem_out(mem_out),
		.mem_hit(mem_hit),
		.io_out(io_out),
		.cpu_din(cpu_din)
	);

endmodule

`default_nettype wire

//--- bus_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "zx81_params.svh"

module bus_read_mux (
	input wire logic clk_sys,
	input wire logic reset,
	cpu_bus_if.mux bus,
	input wire zx81_pkg::cpu_data_t mem_out,
	input wire logic mem_hit,
	input wire zx81_pkg::cpu_data_t io_out,
	output zx81_pkg::cpu_data_t cpu_din
);

	// Cycle type of the previous edge
	logic mem_rd;
	logic io_rd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_rd <= 1'b0;
			io_rd <= 1'b0;
		end else begin
			mem_rd <= ~bus.mreq_n & ~bus.rd_n;
			// Interrupt acknowledge is not a port read
			io_rd <= ~bus.iorq_n & ~bus.rd_n & bus.m1_n;
		end
	end

	always_comb begin
		if (mem_rd & mem_hit)
			cpu_din = mem_out;
		else if (io_rd)
			cpu_din = io_out;
		else
			cpu_din = `ZX81_OPEN_BUS;
	end

endmodule

`default_nettype wire

//--- io_ports.sv
`timescale 1ns/10ps
`default_nettype none

`include "zx81_params.svh"

module io_ports (
	input wire logic clk_sys,
	input wire logic reset,
	cpu_bus_if.io bus,
	input wire zx81_pkg::key_matrix_t key_matrix,
	input wire zx81_pkg::joy_t joystick,
	input wire logic [1:0] joy_mode,
	input wire logic hz50,
	input wire logic chroma_en,
	output zx81_pkg::cpu_data_t io_out
);

	// ============================================================
	// Port selects
	// ============================================================

	logic kbd_rd;
	logic zxp_sel;
	logic chr_sel;

	assign kbd_rd = ~bus.iorq_n & ~bus.rd_n & ~bus.addr[0];
	assign zxp_sel = ~bus.iorq_n & (bus.addr == `ZX81_ZXP_PORT);
	assign chr_sel = ~bus.iorq_n & (bus.addr == `ZX81_CHR_PORT) & chroma_en;

	// ============================================================
	// Keyboard half-rows
	// ============================================================

	zx81_pkg::key_row_t key_data;

	// Upper address byte selects rows, active low
	always_comb begin
		key_data = '1;
		for (int n = 0; n < 8; n++) begin
			if (!bus.addr[8 + n])
				key_data = key_data & key_matrix[5 * n +: 5];
		end
	end

	// ============================================================
	// Joystick to key mapping
	// ============================================================

	logic [4:0] joy_c1;
	logic [4:0] joy_c2;
	logic [4:0] joy_s1;
	logic [4:0] joy_zx;
	logic [4:0] joy_kbd;
	logic zxp_use;

	// Cursor keys 5-8 and 0
	assign joy_c1 = {5{joy_mode == 2'd0}} &
		{joystick[2], joystick[3], joystick[0], 1'b0, joystick[4]};
	assign joy_c2 = {5{joy_mode == 2'd0}} & {joystick[1], 4'b0000};

	// Sinclair left port, keys 6-0
	assign joy_s1 = {5{joy_mode[0]}} &
		{joystick[1:0], joystick[2], joystick[3], joystick[4]};

	// ZX81 keys 6-0
	assign joy_zx = {5{joy_mode[1]}} &
		{joystick[2], joystick[3], joystick[0], joystick[1], joystick[4]};

	// Pull keys low only in the half-row the mapping belongs to
	assign joy_kbd = {5{zxp_use}} |
		(({5{bus.addr[12]}} | ~(joy_s1 | joy_c1 | joy_zx)) &
		({5{bus.addr[11]}} | ~joy_c2));

	// ============================================================
	// Printer port register
	// ============================================================

	zx81_pkg::cpu_data_t zxp_out;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zxp_out <= 8'hFF;
			zxp_use <= 1'b0;
		end else if (zxp_sel & ~bus.wr_n) begin
			case (bus.wdata)
				`ZX81_ZXP_CODE_A: zxp_out <= 8'hF0;
				`ZX81_ZXP_CODE_B: zxp_out <= 8'h0F;
				`ZX81_ZXP_CODE_JOY: begin
					// Joystick moves over to the printer port
					zxp_out <= {~joystick[3:0], ~joystick[4], 3'b000};
					zxp_use <= 1'b1;
				end
				default: zxp_out <= 8'hFF;
			endcase
		end
	end

	// Read data, one cycle after the request
	always_ff @(posedge clk_sys) begin
		if (kbd_rd)
			io_out <= {1'b0, hz50, 1'b0, key_data & joy_kbd};
		else if (zxp_sel)
			io_out <= zxp_out;
		else if (chr_sel)
			io_out <= `ZX81_CHR_ID;
		else
			io_out <= `ZX81_OPEN_BUS;
	end

endmodule

`default_nettype wire

//--- memory_map.sv
`timescale 1ns/10ps
`default_nettype none

`include "zx81_params.svh"

module memory_map (
	input wire logic clk_sys,
	input wire logic reset,
	cpu_bus_if.mem bus,
	input wire zx81_pkg::mem_size_t mem_size,
	input wire logic low_ram_en,
	input wire logic rom_load_we,
	input wire zx81_pkg::rom_addr_t rom_load_addr,
	input wire zx81_pkg::cpu_data_t rom_load_data,
	output zx81_pkg::cpu_data_t mem_out,
	output logic mem_hit
);

	// ============================================================
	// Configuration latch
	// ============================================================

	zx81_pkg::mem_size_t cfg_size;
	logic cfg_low_ram;

	// Follows the inputs only while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_size <= mem_size;
			cfg_low_ram <= low_ram_en;
		end
	end

	// ============================================================
	// Address decode
	// ============================================================

	logic low16k_e;
	logic ram_lo_e;
	logic ram_hi_e;
	logic ram_e;
	logic rom_e;

	// Top 16K belongs to RAM only for 32K and 48K
	assign low16k_e = ~bus.addr[15] | ~cfg_size[1];

	// Optional 8K at 2000h
	assign ram_lo_e = ~bus.addr[14] & bus.addr[13] & low16k_e;

	// 8000h data bank of the 32K and 48K setups
	assign ram_hi_e = bus.addr[15] & cfg_size[1] & ~bus.addr[14];

	assign ram_e = bus.addr[14] | ram_hi_e | (ram_lo_e & cfg_low_ram);
	assign rom_e = ~bus.addr[14] & ~bus.addr[13] & low16k_e;

	// ============================================================
	// RAM address translation
	// ============================================================

	zx81_pkg::ram_addr_t ram_a;

	always_comb begin
		if (ram_lo_e) begin
			// Fixed 8K bank
			ram_a = {3'b001, bus.addr[12:0]};
		end else begin
			case (cfg_size)
				2'd0: ram_a = {6'b010000, bus.addr[9:0]};
				2'd1: ram_a = {2'b01, bus.addr[13:0]};
				2'd2: begin
					// C000h mirrors main, 8000h is the data bank
					if (bus.addr[15:14] == 2'b10)
						ram_a = {2'b10, bus.addr[13:0]};
					else
						ram_a = {2'b01, bus.addr[13:0]};
				end
				default: begin
					case (bus.addr[15:14])
						2'b10: ram_a = {2'b10, bus.addr[13:0]};
						// Separate bank on data cycles, main on opcode fetch
						2'b11: ram_a = {bus.m1_n, 1'b1, bus.addr[13:0]};
						default: ram_a = {2'b01, bus.addr[13:0]};
					endcase
				end
			endcase
		end
	end

	// ============================================================
	// Arrays
	// ============================================================

	zx81_pkg::cpu_data_t ram [`ZX81_RAM_WORDS];
	zx81_pkg::cpu_data_t rom [`ZX81_ROM_WORDS];
	zx81_pkg::cpu_data_t ram_q;
	zx81_pkg::cpu_data_t rom_q;
	logic ram_we;
	logic rom_sel;

	assign ram_we = ~bus.mreq_n & ~bus.wr_n & ram_e;

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram[ram_a] <= bus.wdata;
		ram_q <= ram[ram_a];
	end

	// Loader port writes, CPU side is read only
	always_ff @(posedge clk_sys) begin
		if (rom_load_we)
			rom[rom_load_addr] <= rom_load_data;
		rom_q <= rom[bus.addr[12:0]];
	end

	// Which array answered last cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_hit <= 1'b0;
			rom_sel <= 1'b0;
		end else begin
			mem_hit <= rom_e | ram_e;
			rom_sel <= rom_e;
		end
	end

	assign mem_out = rom_sel ? rom_q : ram_q;

endmodule

`default_nettype wire

//--- cpu_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cpu_bus_if;

	// Address and write data from the CPU
	zx81_pkg::cpu_addr_t addr;
	zx81_pkg::cpu_data_t wdata;

	// Z80 control strobes, all active low
	logic m1_n;
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;

	// Memory map
	modport mem (
		input addr, wdata, m1_n, mreq_n, iorq_n, rd_n, wr_n
	);

	// I/O ports
	modport io (
		input addr, wdata, m1_n, mreq_n, iorq_n, rd_n, wr_n
	);

	// Read data selection
	modport mux (
		input addr, wdata, m1_n, mreq_n, iorq_n, rd_n, wr_n
	);

endinterface

`default_nettype wire

//--- zx81_pkg.sv
`default_nettype none

package zx81_pkg;

	// CPU bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// Memory side
	typedef logic [15:0] ram_addr_t;
	typedef logic [12:0] rom_addr_t;

	// RAM size code: 0 1K, 1 16K, 2 32K, 3 48K
	typedef logic [1:0] mem_size_t;

	// Joystick, bit 0 right .. bit 3 up, bit 4 fire
	typedef logic [4:0] joy_t;

	// One keyboard half-row, active low
	typedef logic [4:0] key_row_t;

	// Eight half-rows, row n at bits 5n+4:5n
	typedef logic [39:0] key_matrix_t;

endpackage

`default_nettype wire

//--- zx81_params.svh
`ifndef ZX81_PARAMS_SVH
`define ZX81_PARAMS_SVH

// ============================================================
// Memory sizes
// ============================================================

// 8 KB ROM, loaded through the side port
`define ZX81_ROM_WORDS 8192

// Full 64 KB RAM array, translated from CPU addresses
`define ZX81_RAM_WORDS 65536

// ============================================================
// I/O port addresses and fixed read values
// ============================================================

// ZX printer / joystick interface
`define ZX81_ZXP_PORT 16'hE007

// CHROMA81 identification port
`define ZX81_CHR_PORT 16'h7FEF
`define ZX81_CHR_ID 8'hDF

// Printer port command bytes
`define ZX81_ZXP_CODE_A 8'hAA
`define ZX81_ZXP_CODE_B 8'h55
`define ZX81_ZXP_CODE_JOY 8'hA0

// Value of an undriven data bus
`define ZX81_OPEN_BUS 8'hFF

`endif
